/* include/hist_params.svh */
`ifndef HIST_PARAMS_SVH
`define HIST_PARAMS_SVH

// Width of one input sample
`define HIST_SAMPLE_W 12

// Bin address width, 32 bins
`define HIST_BIN_AW 5

// Number of bins in the histogram
`define HIST_NUM_BINS (1 << `HIST_BIN_AW)

// Count width, saturates at 255
`define HIST_CNT_W 8

// Width of the scale shift level
`define HIST_SHIFT_W 4

// Forward port B writes to port A reads
`define HIST_BYPASS_B2A 1

`endif

/* rtl/hist_pkg.sv */
`include "hist_params.svh"

package hist_pkg;

   // Raw sample from the host
   typedef logic [`HIST_SAMPLE_W-1:0] sample_t;

   // Bin index into the count RAM
   typedef logic [`HIST_BIN_AW-1:0] bin_t;

   // One bin count
   typedef logic [`HIST_CNT_W-1:0] count_t;

   // Right shift applied after the offset
   typedef logic [`HIST_SHIFT_W-1:0] shift_t;

   // Updater modes
   typedef enum logic {
      UPD_CLEAR,
      UPD_RUN
   } upd_state_t;

endpackage

/* rtl/hist_ram_if.sv */
`timescale 1ns/1ps
`include "hist_params.svh"

interface hist_ram_if #(
   parameter int AW = `HIST_BIN_AW,
   parameter int DW = `HIST_CNT_W
);

   // Port A, clear sweep, update reads and readout
   logic [AW-1:0] addr_a;
   logic          en_a;
   logic          we_a;
   logic [DW-1:0] din_a;
   logic [DW-1:0] dout_a;

   // Port B, incremented count writes
   logic [AW-1:0] addr_b;
   logic          en_b;
   logic          we_b;
   logic [DW-1:0] din_b;
   logic [DW-1:0] dout_b;

   // Updater side drives both ports
   modport updater (
      output addr_a, en_a, we_a, din_a,
      input  dout_a,
      output addr_b, en_b, we_b, din_b,
      input  dout_b
   );

   // RAM side
   modport ram (
      input  addr_a, en_a, we_a, din_a,
      output dout_a,
      input  addr_b, en_b, we_b, din_b,
      output dout_b
   );

endinterface

/* rtl/hist_bin_mapper.sv */
`timescale 1ns/1ps
`include "hist_params.svh"

module hist_bin_mapper (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              sample_valid,
   input  hist_pkg::sample_t sample,
   input  hist_pkg::sample_t lo_bound,
   input  hist_pkg::shift_t  bin_shift,
   output logic              bin_valid,
   output hist_pkg::bin_t    bin
);
   import hist_pkg::*;

   // One extra bit to catch underflow
   logic [`HIST_SAMPLE_W:0]   diff;
   logic                      below_lo;
   sample_t                   scaled;
   logic                      above_hi;
   bin_t                      bin_next;
   logic                      bin_valid_q;
   bin_t                      bin_q;

   // Offset by the lower bound
   assign diff     = {1'b0, sample} - {1'b0, lo_bound};
   assign below_lo = diff[`HIST_SAMPLE_W];

   // Scale down to bin granularity
   assign scaled   = diff[`HIST_SAMPLE_W-1:0] >> bin_shift;

   // Any bit above the bin range means overflow
   assign above_hi = |scaled[`HIST_SAMPLE_W-1:`HIST_BIN_AW];

   // Clamp into 0 .. last bin
   always_comb begin
      if (below_lo) begin
         bin_next = '0;
      end else if (above_hi) begin
         bin_next = '1;
      end else begin
         bin_next = scaled[`HIST_BIN_AW-1:0];
      end
   end

   // Strobe follows sample_valid by one cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bin_valid_q <= 1'b0;
      end else begin
         bin_valid_q <= sample_valid;
      end
   end

   // Index payload only loads on a strobe
   always_ff @(posedge clk) begin
      if (sample_valid) begin
         bin_q <= bin_next;
      end
   end

   assign bin_valid = bin_valid_q;
   assign bin       = bin_q;

   // Offset and shift held still while samples flow
   a_cfg_stable: assert property (
      @(posedge clk) disable iff (!rst_n)
      sample_valid |-> ($stable(lo_bound) && $stable(bin_shift))
   );

endmodule

/* rtl/hist_tdpram.sv */
`timescale 1ns/1ps
`include "hist_params.svh"

module hist_tdpram #(
   parameter int AW                = `HIST_BIN_AW,
   parameter int DW                = `HIST_CNT_W,
   parameter bit ENABLE_BYPASS_B2A = `HIST_BYPASS_B2A
) (
   input logic     clk,
   input logic     rst_n,
   hist_ram_if.ram ram
);

   // Storage, one word per address
   logic [DW-1:0] mem [0:(1<<AW)-1];

   // Per-port output registers
   logic [DW-1:0] dout_a_q;
   logic [DW-1:0] dout_b_q;

   logic wr_a;
   logic wr_b;

   assign wr_a = ram.en_a && ram.we_a;
   assign wr_b = ram.en_b && ram.we_b;

   // Array writes from both ports
   // Same-address dual write is illegal, see assertion below
   always_ff @(posedge clk) begin
      if (wr_a) begin
         mem[ram.addr_a] <= ram.din_a;
      end
      if (wr_b) begin
         mem[ram.addr_b] <= ram.din_b;
      end
   end

   // Port A output, write first
   always_ff @(posedge clk) begin
      if (wr_a) begin
         dout_a_q <= ram.din_a;
      end else if (ram.en_a) begin
         dout_a_q <= mem[ram.addr_a];
      end
   end

   // Port B output, write first
   always_ff @(posedge clk) begin
      if (wr_b) begin
         dout_b_q <= ram.din_b;
      end else if (ram.en_b) begin
         dout_b_q <= mem[ram.addr_b];
      end
   end

   generate
      if (ENABLE_BYPASS_B2A) begin : g_bypass_on
         logic          bypass_q;
         logic [DW-1:0] din_b_q;

         // Captured port B data, sampled on each port A access
         always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
               din_b_q <= '0;
            end else if (ram.en_a) begin
               din_b_q <= ram.din_b;
            end
         end

         // Set when A reads what B writes in the same cycle
         // Held until the next port A access
         always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
               bypass_q <= 1'b0;
            end else if (ram.en_a && wr_b && (ram.addr_a == ram.addr_b)) begin
               bypass_q <= 1'b1;
            end else if (ram.en_a) begin
               bypass_q <= 1'b0;
            end
         end

         assign ram.dout_a = bypass_q ? din_b_q : dout_a_q;
      end else begin : g_bypass_off
         assign ram.dout_a = dout_a_q;
      end
   endgenerate

   assign ram.dout_b = dout_b_q;

   // Both ports must not write one address together
   a_no_dual_write: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(wr_a && wr_b && (ram.addr_a == ram.addr_b))
   );

endmodule

/* rtl/hist_updater.sv */
`timescale 1ns/1ps
`include "hist_params.svh"

module hist_updater (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               bin_valid,
   input  hist_pkg::bin_t     bin,
   input  logic               clear,
   output logic               busy,
   input  logic               rd_strobe,
   input  hist_pkg::bin_t     rd_bin,
   output logic               rd_valid,
   output hist_pkg::count_t   rd_data,
   hist_ram_if.updater        ram
);
   import hist_pkg::*;

   upd_state_t state_q;
   upd_state_t state_d;

   // Clear sweep address
   bin_t       sweep_q;
   logic       sweep_last;

   // Port A requests this cycle
   logic       upd_rd;
   logic       rd_rd;

   // Write stage of the read-modify-write
   logic       pend_valid_q;
   bin_t       pend_addr_q;

   count_t     old_cnt;
   count_t     new_cnt;
   logic       rd_valid_q;

   assign sweep_last = (sweep_q == bin_t'(`HIST_NUM_BINS - 1));

   // Updates win over readout
   // A clear request drops the sample of the same cycle
   assign upd_rd = (state_q == UPD_RUN) && bin_valid && !clear;
   assign rd_rd  = (state_q == UPD_RUN) && rd_strobe && !bin_valid;

   // Mode transitions
   always_comb begin
      state_d = state_q;
      case (state_q)
         UPD_CLEAR: begin
            if (sweep_last) begin
               state_d = UPD_RUN;
            end
         end
         UPD_RUN: begin
            if (clear) begin
               state_d = UPD_CLEAR;
            end
         end
         default: state_d = UPD_CLEAR;
      endcase
   end

   // Starts in the clear sweep
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= UPD_CLEAR;
      end else begin
         state_q <= state_d;
      end
   end

   // Sweep counter, wraps to zero after the last bin
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sweep_q <= '0;
      end else if (state_q == UPD_CLEAR) begin
         sweep_q <= sweep_q + 1'b1;
      end else begin
         sweep_q <= '0;
      end
   end

   // Port A arbitration
   always_comb begin
      ram.en_a   = 1'b0;
      ram.we_a   = 1'b0;
      ram.addr_a = '0;
      ram.din_a  = '0;
      if (state_q == UPD_CLEAR) begin
         // Zero one bin per cycle
         ram.en_a   = 1'b1;
         ram.we_a   = 1'b1;
         ram.addr_a = sweep_q;
      end else if (upd_rd) begin
         ram.en_a   = 1'b1;
         ram.addr_a = bin;
      end else if (rd_rd) begin
         ram.en_a   = 1'b1;
         ram.addr_a = rd_bin;
      end
   end

   // Pending write valid
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pend_valid_q <= 1'b0;
      end else begin
         pend_valid_q <= upd_rd;
      end
   end

   // Pending write address
   always_ff @(posedge clk) begin
      if (upd_rd) begin
         pend_addr_q <= bin;
      end
   end

   // Old count arrives a cycle after the read, bypass included
   assign old_cnt = ram.dout_a;

   // Saturating increment
   assign new_cnt = (old_cnt == '1) ? old_cnt : count_t'(old_cnt + 1'b1);

   // Port B only writes back
   assign ram.en_b   = pend_valid_q;
   assign ram.we_b   = pend_valid_q;
   assign ram.addr_b = pend_addr_q;
   assign ram.din_b  = new_cnt;

   // Readout response one cycle after the strobe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= rd_rd;
      end
   end

   assign rd_valid = rd_valid_q;
   assign rd_data  = ram.dout_a;
   assign busy     = (state_q == UPD_CLEAR);

   // Sweep owns the RAM, no write-backs allowed
   a_no_wb_in_clear: assert property (
      @(posedge clk) disable iff (!rst_n)
      (state_q == UPD_CLEAR) |-> !(ram.en_b && ram.we_b)
   );

   // An update read never produces a readout response
   a_no_rd_after_upd: assert property (
      @(posedge clk) disable iff (!rst_n)
      upd_rd |=> !rd_valid
   );

endmodule

/* rtl/hist_top.sv */
`timescale 1ns/1ps
`include "hist_params.svh"

module hist_top (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              sample_valid,
   input  hist_pkg::sample_t sample,
   input  hist_pkg::sample_t lo_bound,
   input  hist_pkg::shift_t  bin_shift,
   input  logic              clear,
   output logic              busy,
   input  logic              rd_strobe,
   input  hist_pkg::bin_t    rd_bin,
   output logic              rd_valid,
   output hist_pkg::count_t  rd_data
);
   import hist_pkg::*;

   // Mapper to updater
   logic bin_valid;
   bin_t bin;

   // Updater to RAM
   hist_ram_if #(
      .AW (`HIST_BIN_AW),
      .DW (`HIST_CNT_W)
   ) ram_bus ();

   // Producer
   hist_bin_mapper mapper_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .sample       (sample),
      .lo_bound     (lo_bound),
      .bin_shift    (bin_shift),
      .bin_valid    (bin_valid),
      .bin          (bin)
   );

   // Count storage, port B data out not needed
   hist_tdpram #(
      .AW                (`HIST_BIN_AW),
      .DW                (`HIST_CNT_W),
      .ENABLE_BYPASS_B2A (`HIST_BYPASS_B2A)
   ) ram_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .ram   (ram_bus.ram)
   );

   // Consumer
   hist_updater updater_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .bin_valid (bin_valid),
      .bin       (bin),
      .clear     (clear),
      .busy      (busy),
      .rd_strobe (rd_strobe),
      .rd_bin    (rd_bin),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data),
      .ram       (ram_bus.updater)
   );

endmodule

/* testbench/hist_tb.sv */
`timescale 1ns/1ps
`include "hist_params.svh"

module hist_tb;
   import hist_pkg::*;

   localparam int NUM_BINS = `HIST_NUM_BINS;
   localparam int CNT_MAX  = (1 << `HIST_CNT_W) - 1;

   // Cycle budget per phase, reads take 2 cycles each
   localparam int RESET_CYCLES    = 10 + 40;
   localparam int READ_CYCLES     = 5 * NUM_BINS * 2 + 10;
   localparam int DIRECTED_CYCLES = 10 * 4 + 40;
   localparam int STREAM_CYCLES   = 300 * 3 + 10;
   localparam int CLEAR_CYCLES    = 40;
   localparam int SAT_CYCLES      = 300 + 20;
   localparam int MARGIN_CYCLES   = 300;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + READ_CYCLES + DIRECTED_CYCLES
                                    + STREAM_CYCLES + CLEAR_CYCLES + SAT_CYCLES
                                    + MARGIN_CYCLES;

   logic    clk;
   logic    rst_n;
   logic    sample_valid;
   sample_t sample;
   sample_t lo_bound;
   shift_t  bin_shift;
   logic    clear;
   logic    busy;
   logic    rd_strobe;
   bin_t    rd_bin;
   logic    rd_valid;
   count_t  rd_data;

   int      errors;
   integer  seed;

   // Reference counts, one per bin
   int      model [NUM_BINS];

   hist_top hist_top_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .sample_valid (sample_valid),
      .sample       (sample),
      .lo_bound     (lo_bound),
      .bin_shift    (bin_shift),
      .clear        (clear),
      .busy         (busy),
      .rd_strobe    (rd_strobe),
      .rd_bin       (rd_bin),
      .rd_valid     (rd_valid),
      .rd_data      (rd_data)
   );

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Offset, shift, clamp to the last bin
   function automatic int expected_bin(input int s, input int lo, input int sh);
      int d;
      if (s < lo) begin
         return 0;
      end
      d = (s - lo) >> sh;
      if (d > NUM_BINS - 1) begin
         return NUM_BINS - 1;
      end
      return d;
   endfunction

   // Count stops at the top
   function automatic int saturated_inc(input int c);
      if (c >= CNT_MAX) begin
         return CNT_MAX;
      end
      return c + 1;
   endfunction

   task automatic check_value(input string name, input int exp, input int got);
      if (exp != got) begin
         $display("ERROR at %0t ns: %s expected %0d got %0d", $time, name, exp, got);
         errors++;
      end
   endtask

   // Drops every strobe after the next edge
   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         sample_valid <= 1'b0;
         rd_strobe    <= 1'b0;
         clear        <= 1'b0;
      end
   endtask

   // One strobe cycle, model follows only if the sample should count
   task automatic strobe_sample(input int s, input bit counted);
      int b;
      @(posedge clk);
      sample_valid <= 1'b1;
      sample       <= sample_t'(s);
      b = expected_bin(s, int'(lo_bound), int'(bin_shift));
      if (counted) begin
         model[b] = saturated_inc(model[b]);
      end
   endtask

   task automatic read_bin(input int b, input int exp);
      @(posedge clk);
      sample_valid <= 1'b0;
      rd_strobe    <= 1'b1;
      rd_bin       <= bin_t'(b);
      @(posedge clk);
      rd_strobe <= 1'b0;
      // Response settles after the edge that took the strobe
      @(negedge clk);
      if (!rd_valid) begin
         $display("ERROR at %0t ns: no read response for bin %0d", $time, b);
         errors++;
      end else begin
         check_value($sformatf("rd_data[bin %0d]", b), exp, int'(rd_data));
      end
   endtask

   task automatic check_all_bins();
      for (int b = 0; b < NUM_BINS; b++) begin
         read_bin(b, model[b]);
      end
   endtask

   // Counts busy cycles at falling edges, bounded
   task automatic measure_busy(input string what);
      int n;
      n = 0;
      @(negedge clk);
      while (busy && n < 100) begin
         n++;
         @(negedge clk);
      end
      check_value({what, " busy cycles"}, NUM_BINS, n);
   endtask

   task automatic test_reset_sweep();
      measure_busy("reset");
      check_all_bins();
   endtask

   task automatic test_isolated();
      int samples [10];
      samples = '{0, 99, 100, 115, 116, 300, 611, 612, 4095, 150};
      foreach (samples[i]) begin
         strobe_sample(samples[i], 1'b1);
         idle(3);
      end
      check_all_bins();
   endtask

   // Same bin back to back, then two bins in turn
   task automatic test_back_to_back();
      repeat (16) begin
         strobe_sample(200, 1'b1);
      end
      idle(2);
      for (int i = 0; i < 16; i++) begin
         strobe_sample((i % 2 == 1) ? 260 : 420, 1'b1);
      end
      idle(3);
      check_all_bins();
   endtask

   task automatic test_random_stream();
      int s;
      int gap;
      repeat (300) begin
         s = {$random(seed)} % 4096;
         strobe_sample(s, 1'b1);
         gap = {$random(seed)} % 3;
         if (gap > 0) begin
            idle(gap);
         end
      end
      idle(3);
      check_all_bins();
   endtask

   task automatic test_clear();
      @(posedge clk);
      clear <= 1'b1;
      @(posedge clk);
      clear <= 1'b0;
      foreach (model[b]) begin
         model[b] = 0;
      end
      fork
         measure_busy("clear");
         begin
            // Dropped, the sweep owns the RAM
            repeat (10) begin
               strobe_sample(250, 1'b0);
            end
            idle(1);
         end
      join
      idle(2);
      check_all_bins();
   endtask

   task automatic test_saturation();
      repeat (3) begin
         strobe_sample(230, 1'b1);
      end
      idle(2);
      repeat (300) begin
         strobe_sample(212, 1'b1);
      end
      idle(3);
      read_bin(7, CNT_MAX);
      read_bin(8, model[8]);
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("Summary: %0d errors", errors);
      $display("Regression failed");
      $finish;
   end

   initial begin
      errors       = 0;
      seed         = 32'hc5b61abb;
      rst_n        = 1'b0;
      sample_valid = 1'b0;
      sample       = '0;
      lo_bound     = sample_t'(100);
      bin_shift    = shift_t'(4);
      clear        = 1'b0;
      rd_strobe    = 1'b0;
      rd_bin       = '0;
      foreach (model[b]) begin
         model[b] = 0;
      end

      repeat (10) @(posedge clk);
      // Reset values while rst_n is still low
      check_value("busy", 1, int'(busy));
      check_value("rd_valid", 0, int'(rd_valid));
      rst_n <= 1'b1;

      test_reset_sweep();
      test_isolated();
      test_back_to_back();
      test_random_stream();
      test_clear();
      test_saturation();

      $display("Summary: %0d errors", errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* hist.f */
+incdir+include
rtl/hist_pkg.sv
rtl/hist_ram_if.sv
rtl/hist_bin_mapper.sv
rtl/hist_tdpram.sv
rtl/hist_updater.sv
rtl/hist_top.sv
testbench/hist_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the histogram regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module hist_tb \
   -f hist.f \
   -o hist_sim

output="$(./obj_dir/hist_sim)"
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
   exit 0
else
   exit 1
fi
